/* verilog/ibex_shell_settings.svh */
////////////////////////////////////////////////////////////////////////////
// Shell widths, register count and the scramble defaults loaded at reset
////////////////////////////////////////////////////////////////////////////

`ifndef IBEX_SHELL_SETTINGS_SVH
`define IBEX_SHELL_SETTINGS_SVH

// Register file geometry
`define IBEX_SHELL_XLEN        32
`define IBEX_SHELL_FLEN        16
`define IBEX_SHELL_NUM_REGS    32
`define IBEX_SHELL_REG_ADDR_W  5

// Instruction cache scrambling
`define IBEX_SHELL_KEY_W       128
`define IBEX_SHELL_NONCE_W     64

`define IBEX_SHELL_KEY_DEFAULT   128'h14e8_ceca_e304_0d5e_1228_6bb3_cc11_3298
`define IBEX_SHELL_NONCE_DEFAULT 64'hf797_80bc_735f_3843

`endif

/* verilog/ibex_shell_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types for the shell: register words, register index,
// scramble key and nonce
////////////////////////////////////////////////////////////////////////////

`include "ibex_shell_settings.svh"

package ibex_shell_pkg;

  // Integer register word
  typedef logic [`IBEX_SHELL_XLEN-1:0] word_t;

  // Stored bfloat16 value
  typedef logic [`IBEX_SHELL_FLEN-1:0] fp_word_t;

  typedef logic [`IBEX_SHELL_REG_ADDR_W-1:0] reg_addr_t;

  // Scrambling
  typedef logic [`IBEX_SHELL_KEY_W-1:0]   scr_key_t;
  typedef logic [`IBEX_SHELL_NONCE_W-1:0] scr_nonce_t;

endpackage

/* verilog/rf_bank.sv */
////////////////////////////////////////////////////////////////////////////
// Flip-flop register bank, two combinational read ports and one write
// port, generic in its word type
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "ibex_shell_settings.svh"

module rf_bank import ibex_shell_pkg::*; #(
  parameter type word_t   = logic [`IBEX_SHELL_XLEN-1:0],
  // Entry 0 reads as zero and ignores writes
  parameter bit  HardZero = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      we_i,

  output word_t     rdata_a_o,
  output word_t     rdata_b_o
);

  word_t mem_q [`IBEX_SHELL_NUM_REGS];
  logic  wr_en;

  // Drop writes aimed at the hard-wired zero entry
  assign wr_en = we_i & ~(HardZero & (waddr_i == '0));

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `IBEX_SHELL_NUM_REGS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Reads are purely combinational
  assign rdata_a_o = mem_q[raddr_a_i];
  assign rdata_b_o = mem_q[raddr_b_i];

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // An unknown enable would corrupt an arbitrary entry
  we_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(we_i)
  ) else $error("rf_bank write enable is unknown");

endmodule

/* verilog/regfile_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Split register file: integer bank and bfloat16 bank behind one write
// port and two read ports, with NaN-boxing of floating-point reads
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module regfile_unit import ibex_shell_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      we_i,

  // Bank selects from the core
  input  logic      fp_wdata_sel_i,
  input  logic      fp_rdata_a_sel_i,
  input  logic      fp_rdata_b_sel_i,

  output word_t     rdata_a_o,
  output word_t     rdata_b_o
);

  // Upper bits forced to ones on a floating-point read
  localparam int unsigned BoxW = $bits(word_t) - $bits(fp_word_t);

  logic     int_we;
  logic     fp_we;
  fp_word_t fp_wdata;
  word_t    int_rdata_a;
  word_t    int_rdata_b;
  fp_word_t fp_rdata_a;
  fp_word_t fp_rdata_b;
  word_t    fp_boxed_a;
  word_t    fp_boxed_b;

  // Write steering
  assign int_we   = we_i & ~fp_wdata_sel_i;
  assign fp_we    = we_i & fp_wdata_sel_i;
  assign fp_wdata = wdata_i[$bits(fp_word_t)-1:0];

  rf_bank #(
    .word_t  (word_t),
    .HardZero(1'b1)
  ) u_int_bank (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(raddr_a_i),
    .raddr_b_i(raddr_b_i),
    .waddr_i  (waddr_i),
    .wdata_i  (wdata_i),
    .we_i     (int_we),
    .rdata_a_o(int_rdata_a),
    .rdata_b_o(int_rdata_b)
  );

  rf_bank #(
    .word_t  (fp_word_t),
    .HardZero(1'b0)
  ) u_fp_bank (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(raddr_a_i),
    .raddr_b_i(raddr_b_i),
    .waddr_i  (waddr_i),
    .wdata_i  (fp_wdata),
    .we_i     (fp_we),
    .rdata_a_o(fp_rdata_a),
    .rdata_b_o(fp_rdata_b)
  );

  // NaN-boxing
  assign fp_boxed_a = {{BoxW{1'b1}}, fp_rdata_a};
  assign fp_boxed_b = {{BoxW{1'b1}}, fp_rdata_b};

  // Each read port picks its own bank
  assign rdata_a_o = fp_rdata_a_sel_i ? fp_boxed_a : int_rdata_a;
  assign rdata_b_o = fp_rdata_b_sel_i ? fp_boxed_b : int_rdata_b;

  sel_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    we_i |-> !$isunknown({fp_wdata_sel_i, fp_rdata_a_sel_i, fp_rdata_b_sel_i})
  ) else $error("regfile_unit bank select unknown during write");

endmodule

/* verilog/scramble_key_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Instruction cache scrambling key and nonce registers, with the key
// request/valid handshake toward the key provider
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "ibex_shell_settings.svh"

module scramble_key_ctrl import ibex_shell_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Invalidation pulse from the cache side
  input  logic       icache_inval_i,

  // Key provider
  input  logic       scramble_key_valid_i,
  input  scr_key_t   scramble_key_i,
  input  scr_nonce_t scramble_nonce_i,
  output logic       scramble_req_o,

  // Toward the cache RAMs
  output logic       scr_key_valid_o,
  output scr_key_t   scr_key_o,
  output scr_nonce_t scr_nonce_o
);

  scr_key_t   key_q;
  scr_nonce_t nonce_q;
  logic       req_d, req_q;
  logic       key_valid_d, key_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Key and nonce
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= `IBEX_SHELL_KEY_DEFAULT;
      nonce_q <= `IBEX_SHELL_NONCE_DEFAULT;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request state
  ////////////////////////////////////////////////////////////////////////////

  // Request holds until the provider answers, new invalidations ignored meanwhile
  assign req_d       = req_q ? ~scramble_key_valid_i : icache_inval_i;
  assign key_valid_d = req_q          ? scramble_key_valid_i :
                       icache_inval_i ? 1'b0                 :
                                        key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  assign scramble_req_o  = req_q;
  assign scr_key_valid_o = key_valid_q;
  assign scr_key_o       = key_q;
  assign scr_nonce_o     = nonce_q;

  req_vs_valid_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(req_q && key_valid_q)
  ) else $error("key request and key valid both high");

  // Only the provider's valid ends a request
  req_fall_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(req_q) |-> $past(scramble_key_valid_i)
  ) else $error("key request dropped without provider valid");

endmodule

/* verilog/sleep_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Sleep control: busy register, wake condition and the latch-based
// clock gate for the register files
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sleep_ctrl import ibex_shell_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  input  logic test_en_i,

  output logic clk_gated_o,
  output logic core_sleep_o
);

  logic busy_q;
  logic clock_en;
  logic en_latch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  // Wake on work, debug or any interrupt
  assign clock_en     = busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  // Enable sampled while the clock is low, so the gated clock never glitches
  always_latch begin
    if (!clk_i) begin
      en_latch = clock_en | test_en_i;
    end
  end

  assign clk_gated_o = clk_i & en_latch;

  sleep_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(core_sleep_o)
  ) else $error("core_sleep_o is unknown");

endmodule

/* verilog/ibex_shell.sv */
////////////////////////////////////////////////////////////////////////////
// Shell around the core: sleep control with clock gating, split
// register file and the scrambling key controller
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ibex_shell import ibex_shell_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       test_en_i,

  // Sleep and wake
  input  logic       core_busy_i,
  input  logic       debug_req_i,
  input  logic       irq_pending_i,
  input  logic       irq_nm_i,
  output logic       core_sleep_o,

  // Register file, core side
  input  reg_addr_t  rf_raddr_a_i,
  input  reg_addr_t  rf_raddr_b_i,
  input  reg_addr_t  rf_waddr_i,
  input  word_t      rf_wdata_i,
  input  logic       rf_we_i,
  input  logic       rf_fp_wdata_sel_i,
  input  logic       rf_fp_rdata_a_sel_i,
  input  logic       rf_fp_rdata_b_sel_i,
  output word_t      rf_rdata_a_o,
  output word_t      rf_rdata_b_o,

  // Scrambling
  input  logic       icache_inval_i,
  input  logic       scramble_key_valid_i,
  input  scr_key_t   scramble_key_i,
  input  scr_nonce_t scramble_nonce_i,
  output logic       scramble_req_o,
  output logic       scr_key_valid_o,
  output scr_key_t   scr_key_o,
  output scr_nonce_t scr_nonce_o
);

  logic clk_gated;

  sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .test_en_i    (test_en_i),
    .clk_gated_o  (clk_gated),
    .core_sleep_o (core_sleep_o)
  );

  // Register files run on the gated clock
  regfile_unit u_regfile_unit (
    .clk_i           (clk_gated),
    .rst_ni          (rst_ni),
    .raddr_a_i       (rf_raddr_a_i),
    .raddr_b_i       (rf_raddr_b_i),
    .waddr_i         (rf_waddr_i),
    .wdata_i         (rf_wdata_i),
    .we_i            (rf_we_i),
    .fp_wdata_sel_i  (rf_fp_wdata_sel_i),
    .fp_rdata_a_sel_i(rf_fp_rdata_a_sel_i),
    .fp_rdata_b_sel_i(rf_fp_rdata_b_sel_i),
    .rdata_a_o       (rf_rdata_a_o),
    .rdata_b_o       (rf_rdata_b_o)
  );

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .scr_key_valid_o     (scr_key_valid_o),
    .scr_key_o           (scr_key_o),
    .scr_nonce_o         (scr_nonce_o)
  );

endmodule

/* verif/ibex_shell_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the shell: clock, reset, seeded random stimulus, model
// of both banks, sleep gating and key handshake, checks and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "ibex_shell_settings.svh"

module ibex_shell_tb import ibex_shell_pkg::*; ();

  localparam int unsigned SweepCycles = `IBEX_SHELL_NUM_REGS;
  localparam int unsigned RandCycles  = 250;
  localparam int unsigned TotalCycles = 2 + 2 * SweepCycles + 5 * RandCycles;
  localparam int unsigned BoxW        = `IBEX_SHELL_XLEN - `IBEX_SHELL_FLEN;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       test_en_i;
  logic       core_busy_i;
  logic       debug_req_i;
  logic       irq_pending_i;
  logic       irq_nm_i;
  logic       core_sleep_o;
  reg_addr_t  rf_raddr_a_i;
  reg_addr_t  rf_raddr_b_i;
  reg_addr_t  rf_waddr_i;
  word_t      rf_wdata_i;
  logic       rf_we_i;
  logic       rf_fp_wdata_sel_i;
  logic       rf_fp_rdata_a_sel_i;
  logic       rf_fp_rdata_b_sel_i;
  word_t      rf_rdata_a_o;
  word_t      rf_rdata_b_o;
  logic       icache_inval_i;
  logic       scramble_key_valid_i;
  scr_key_t   scramble_key_i;
  scr_nonce_t scramble_nonce_i;
  logic       scramble_req_o;
  logic       scr_key_valid_o;
  scr_key_t   scr_key_o;
  scr_nonce_t scr_nonce_o;

  // Reference model state
  word_t       m_int_rf [`IBEX_SHELL_NUM_REGS];
  fp_word_t    m_fp_rf  [`IBEX_SHELL_NUM_REGS];
  logic        m_busy_q;
  logic        m_req;
  logic        m_key_valid;
  scr_key_t    m_key;
  scr_nonce_t  m_nonce;
  int unsigned n_errors;
  int unsigned n_checks;
  int unsigned n_blocked;
  int unsigned n_ignored;

  ibex_shell uut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .test_en_i           (test_en_i),
    .core_busy_i         (core_busy_i),
    .debug_req_i         (debug_req_i),
    .irq_pending_i       (irq_pending_i),
    .irq_nm_i            (irq_nm_i),
    .core_sleep_o        (core_sleep_o),
    .rf_raddr_a_i        (rf_raddr_a_i),
    .rf_raddr_b_i        (rf_raddr_b_i),
    .rf_waddr_i          (rf_waddr_i),
    .rf_wdata_i          (rf_wdata_i),
    .rf_we_i             (rf_we_i),
    .rf_fp_wdata_sel_i   (rf_fp_wdata_sel_i),
    .rf_fp_rdata_a_sel_i (rf_fp_rdata_a_sel_i),
    .rf_fp_rdata_b_sel_i (rf_fp_rdata_b_sel_i),
    .rf_rdata_a_o        (rf_rdata_a_o),
    .rf_rdata_b_o        (rf_rdata_b_o),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .scr_key_valid_o     (scr_key_valid_o),
    .scr_key_o           (scr_key_o),
    .scr_nonce_o         (scr_nonce_o)
  );

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Model
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t expected_read(reg_addr_t addr, logic fp_sel);
    if (fp_sel) begin
      return {{BoxW{1'b1}}, m_fp_rf[addr]};
    end else if (addr == '0) begin
      return '0;
    end
    return m_int_rf[addr];
  endfunction

  // Called right after a rising edge, inputs still hold their falling-edge values
  task automatic update_model();
    logic gate;
    gate = m_busy_q | debug_req_i | irq_pending_i | irq_nm_i | test_en_i;
    if (rf_we_i && !gate) begin
      n_blocked++;
    end else if (rf_we_i && rf_fp_wdata_sel_i) begin
      m_fp_rf[rf_waddr_i] = rf_wdata_i[`IBEX_SHELL_FLEN-1:0];
    end else if (rf_we_i && rf_waddr_i != '0) begin
      m_int_rf[rf_waddr_i] = rf_wdata_i;
    end
    m_busy_q = core_busy_i;
    if (m_req) begin
      if (icache_inval_i) begin
        n_ignored++;
      end
      m_key_valid = scramble_key_valid_i;
      m_req       = ~scramble_key_valid_i;
    end else if (icache_inval_i) begin
      m_req       = 1'b1;
      m_key_valid = 1'b0;
    end
    if (scramble_key_valid_i) begin
      m_key   = scramble_key_i;
      m_nonce = scramble_nonce_i;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks and stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_error(string msg);
    n_errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic check_outputs();
    word_t exp_a;
    word_t exp_b;
    logic  exp_sleep;
    exp_a     = expected_read(rf_raddr_a_i, rf_fp_rdata_a_sel_i);
    exp_b     = expected_read(rf_raddr_b_i, rf_fp_rdata_b_sel_i);
    exp_sleep = ~(m_busy_q | debug_req_i | irq_pending_i | irq_nm_i);
    n_checks++;
    if (rf_rdata_a_o !== exp_a) begin
      report_error($sformatf("rf_rdata_a_o reg %0d got %h, expected %h",
                             rf_raddr_a_i, rf_rdata_a_o, exp_a));
    end
    if (rf_rdata_b_o !== exp_b) begin
      report_error($sformatf("rf_rdata_b_o reg %0d got %h, expected %h",
                             rf_raddr_b_i, rf_rdata_b_o, exp_b));
    end
    if (core_sleep_o !== exp_sleep) begin
      report_error($sformatf("core_sleep_o got %b, expected %b", core_sleep_o, exp_sleep));
    end
    if (scramble_req_o !== m_req || scr_key_valid_o !== m_key_valid) begin
      report_error($sformatf("req/key_valid got %b/%b, expected %b/%b",
                             scramble_req_o, scr_key_valid_o, m_req, m_key_valid));
    end
    if (scr_key_o !== m_key || scr_nonce_o !== m_nonce) begin
      report_error($sformatf("key/nonce got %h/%h, expected %h/%h",
                             scr_key_o, scr_nonce_o, m_key, m_nonce));
    end
  endtask

  // Inputs are already driven just after a falling edge
  task automatic tick();
    #10;
    check_outputs();
    @(posedge clk_i);
    update_model();
    @(negedge clk_i);
  endtask

  // Integer path on port A, floating-point path on port B, every index
  task automatic sweep_reads();
    rf_we_i = 1'b0;
    for (int i = 0; i < SweepCycles; i++) begin
      rf_raddr_a_i        = reg_addr_t'(i);
      rf_raddr_b_i        = reg_addr_t'(i);
      rf_fp_rdata_a_sel_i = 1'b0;
      rf_fp_rdata_b_sel_i = 1'b1;
      tick();
    end
  endtask

  task automatic run_random(bit fp_mix, bit rand_wake, bit force_clk);
    for (int i = 0; i < RandCycles; i++) begin
      rf_raddr_a_i        = reg_addr_t'($urandom);
      rf_raddr_b_i        = reg_addr_t'($urandom);
      rf_waddr_i          = reg_addr_t'($urandom);
      rf_wdata_i          = $urandom;
      rf_we_i             = ($urandom % 4) != 0;
      rf_fp_wdata_sel_i   = fp_mix && (($urandom % 2) == 1);
      rf_fp_rdata_a_sel_i = fp_mix && (($urandom % 2) == 1);
      rf_fp_rdata_b_sel_i = fp_mix && (($urandom % 2) == 1);
      core_busy_i         = rand_wake ? (($urandom % 4) == 0) : !force_clk;
      debug_req_i         = rand_wake && (($urandom % 8) == 0);
      irq_pending_i       = rand_wake && (($urandom % 8) == 0);
      irq_nm_i            = rand_wake && (($urandom % 16) == 0);
      test_en_i           = force_clk;
      tick();
    end
  endtask

  // Provider answers each request after a random delay
  task automatic run_key_handshake();
    int unsigned delay;
    bit          waiting;
    waiting     = 1'b0;
    delay       = 0;
    rf_we_i     = 1'b0;
    test_en_i   = 1'b0;
    core_busy_i = 1'b0;
    for (int i = 0; i < RandCycles; i++) begin
      icache_inval_i       = ($urandom % 6) == 0;
      scramble_key_i       = {$urandom, $urandom, $urandom, $urandom};
      scramble_nonce_i     = {$urandom, $urandom};
      scramble_key_valid_i = 1'b0;
      if (m_req && !waiting) begin
        waiting = 1'b1;
        delay   = $urandom % 8;
      end
      if (waiting && delay == 0) begin
        scramble_key_valid_i = 1'b1;
        waiting              = 1'b0;
      end else if (waiting) begin
        delay--;
      end
      tick();
    end
    icache_inval_i       = 1'b0;
    scramble_key_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h6d79));
    n_errors  = 0;
    n_checks  = 0;
    n_blocked = 0;
    n_ignored = 0;
    rst_ni               = 1'b0;
    test_en_i            = 1'b0;
    core_busy_i          = 1'b0;
    debug_req_i          = 1'b0;
    irq_pending_i        = 1'b0;
    irq_nm_i             = 1'b0;
    rf_raddr_a_i         = '0;
    rf_raddr_b_i         = '0;
    rf_waddr_i           = '0;
    rf_wdata_i           = '0;
    rf_we_i              = 1'b0;
    rf_fp_wdata_sel_i    = 1'b0;
    rf_fp_rdata_a_sel_i  = 1'b0;
    rf_fp_rdata_b_sel_i  = 1'b0;
    icache_inval_i       = 1'b0;
    scramble_key_valid_i = 1'b0;
    scramble_key_i       = '0;
    scramble_nonce_i     = '0;
    for (int i = 0; i < `IBEX_SHELL_NUM_REGS; i++) begin
      m_int_rf[i] = '0;
      m_fp_rf[i]  = '0;
    end
    m_busy_q    = 1'b0;
    m_req       = 1'b0;
    m_key_valid = 1'b1;
    m_key       = `IBEX_SHELL_KEY_DEFAULT;
    m_nonce     = `IBEX_SHELL_NONCE_DEFAULT;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    sweep_reads();
    run_random(1'b0, 1'b0, 1'b0);
    run_random(1'b1, 1'b0, 1'b0);
    sweep_reads();
    // Sleep gating, then writes forced through by test enable
    run_random(1'b1, 1'b1, 1'b0);
    run_random(1'b1, 1'b0, 1'b1);
    run_key_handshake();

    $display("Checks: %0d, errors: %0d, blocked writes: %0d, ignored invalidations: %0d",
             n_checks, n_errors, n_blocked, n_ignored);
    if (n_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(2 * TotalCycles * 100);
    $display("Timeout: the run did not finish within %0d clock cycles", 2 * TotalCycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* ibex_shell.f */
+incdir+verilog
verilog/ibex_shell_pkg.sv
verilog/rf_bank.sv
verilog/regfile_unit.sv
verilog/scramble_key_ctrl.sv
verilog/sleep_ctrl.sv
verilog/ibex_shell.sv
verif/ibex_shell_tb.sv

/* Makefile */
# Verilator build and run for the ibex_shell testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := ibex_shell_tb
FILELIST := ibex_shell.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "PASS"; \
	else \
	  echo "FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
